// File: testbench/audio_tests.mem
// word 0: sample count N, words 1..N: recorded samples
// then per scenario: fast flag, speed, pause after this many outputs (0 = none)
000c
a5c3
0001
8000
7fff
1234
fedc
5a5a
0ff0
c001
3c3c
9e37
4b1d
// normal playback
0001
0000
0000
// fast, speed 2
0001
0002
0000
// slow, speed 1
0000
0001
0000
// normal playback, paused after 5 outputs
0001
0000
0005

// File: list.f
src/audio_pkg.sv
src/audio_recorder.sv
src/sample_store.sv
src/audio_player.sv
src/audio_ctrl.sv
src/audio_top.sv
testbench/audio_properties.sv
testbench/audio_tb.sv

// File: Makefile
TOP = audio_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/audio_tb.sv
`timescale 1ns/1ps

module audio_tb import audio_pkg::*; ();

	localparam int NUM_SCEN   = 4;
	localparam int MEM_WORDS  = 64;
	localparam int BIT_GAP    = 4;
	localparam int FRAME_GAP  = 8;
	localparam int VALID_WAIT = 20;
	localparam int DONE_WAIT  = 40;
	localparam int BTN_START  = 0;
	localparam int BTN_PAUSE  = 1;
	localparam int BTN_STOP   = 2;

	logic        i_clk;
	logic        i_rst_n;
	logic        i_start;
	logic        i_pause;
	logic        i_stop;
	logic        i_play_mode;
	logic        i_fast;
	speed_t      i_speed;
	logic        i_bit_en;
	logic        i_adc_bit;
	logic        i_frame;
	sample_t     o_dac_data;
	logic        o_dac_valid;
	addr_t       o_end_addr;
	ctrl_state_t o_state;

	integer      seed = 32'h795f;
	int          errors;
	int          watchdog_cycles;
	int          num_samples;
	logic [15:0] tests_mem [MEM_WORDS];
	// expected sample index per frame
	int          exp_idx [$];

	audio_top dut_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_pause     (i_pause),
		.i_stop      (i_stop),
		.i_play_mode (i_play_mode),
		.i_fast      (i_fast),
		.i_speed     (i_speed),
		.i_bit_en    (i_bit_en),
		.i_adc_bit   (i_adc_bit),
		.i_frame     (i_frame),
		.o_dac_data  (o_dac_data),
		.o_dac_valid (o_dac_valid),
		.o_end_addr  (o_end_addr),
		.o_state     (o_state)
	);

	// 20 ns period
	always #10 i_clk = ~i_clk;

	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_state(input ctrl_state_t got, input ctrl_state_t exp);
		if (got !== exp) begin
			errors++;
			$display("error %0t: state got %s expected %s", $time, got.name(), exp.name());
		end
	endtask

	// 0..3 extra idle cycles
	function automatic int jitter();
		return $unsigned($random(seed)) % 4;
	endfunction

	// speed rule of the player, fast skips and slow repeats
	function automatic void build_expected(input bit fast, input int spd, input int n);
		exp_idx.delete();
		if (fast) begin
			for (int a = 0; a < n; a += spd + 1) begin
				exp_idx.push_back(a);
			end
		end else begin
			for (int a = 0; a < n; a++) begin
				repeat (spd + 1) exp_idx.push_back(a);
			end
		end
	endfunction

	// one-cycle button pulse, returns after the state has moved
	task automatic press_button(input int which);
		@(posedge i_clk);
		case (which)
			BTN_START: i_start <= 1'b1;
			BTN_PAUSE: i_pause <= 1'b1;
			default:   i_stop  <= 1'b1;
		endcase
		@(posedge i_clk);
		i_start <= 1'b0;
		i_pause <= 1'b0;
		i_stop  <= 1'b0;
		@(negedge i_clk);
	endtask

	// serial ADC word, msb first
	task automatic send_sample(input sample_t s);
		int gap;
		for (int b = SAMPLE_W - 1; b >= 0; b--) begin
			@(posedge i_clk);
			i_bit_en  <= 1'b1;
			i_adc_bit <= s[b];
			@(posedge i_clk);
			i_bit_en  <= 1'b0;
			// strobe to strobe is gap + 2
			gap = BIT_GAP - 2 + jitter();
			repeat (gap) @(posedge i_clk);
		end
	endtask

	task automatic play_frame(input int idx);
		bit seen;
		seen = 1'b0;
		@(posedge i_clk);
		i_frame <= 1'b1;
		@(posedge i_clk);
		i_frame <= 1'b0;
		for (int c = 0; c < VALID_WAIT && !seen; c++) begin
			@(negedge i_clk);
			seen = o_dac_valid;
		end
		if (seen) begin
			check_sample(o_dac_data, sample_t'(tests_mem[1 + idx]), "dac word");
		end else begin
			errors++;
			$display("no dac output for sample %0d within %0d cycles of the frame",
				idx, VALID_WAIT);
		end
		// valid came 2 cycles after the frame, keep 8 or more between frames
		repeat (FRAME_GAP - 3 + jitter()) @(posedge i_clk);
		check_sample(o_dac_data, sample_t'(tests_mem[1 + idx]), "held dac word");
	endtask

	// frames while paused must not produce output
	task automatic pause_window();
		bit seen;
		seen = 1'b0;
		press_button(BTN_PAUSE);
		check_state(o_state, S_PLAY_PAUSE);
		repeat (3) begin
			@(posedge i_clk);
			i_frame <= 1'b1;
			@(posedge i_clk);
			i_frame <= 1'b0;
			repeat (FRAME_GAP) begin
				@(negedge i_clk);
				if (o_dac_valid) seen = 1'b1;
			end
		end
		if (seen) begin
			errors++;
			$display("dac output appeared while playback was paused");
		end
		press_button(BTN_START);
		check_state(o_state, S_PLAY);
	endtask

	task automatic wait_idle();
		for (int c = 0; c < DONE_WAIT && o_state != S_IDLE; c++) begin
			@(negedge i_clk);
		end
		check_state(o_state, S_IDLE);
	endtask

	initial begin
		int  base;
		int  spd;
		int  pause_at;
		bit  fast_mode;
		i_clk       = 1'b0;
		i_rst_n     = 1'b0;
		i_start     = 1'b0;
		i_pause     = 1'b0;
		i_stop      = 1'b0;
		i_play_mode = 1'b0;
		i_fast      = 1'b0;
		i_speed     = '0;
		i_bit_en    = 1'b0;
		i_adc_bit   = 1'b0;
		i_frame     = 1'b0;
		errors      = 0;
		$readmemh("testbench/audio_tests.mem", tests_mem);
		num_samples = int'(tests_mem[0]);
		// worst case record plus slowest playback per scenario
		watchdog_cycles = 2000 + num_samples * SAMPLE_W * (BIT_GAP + 4)
			+ NUM_SCEN * num_samples * 16 * (VALID_WAIT + FRAME_GAP + 4);
		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		check_state(o_state, S_IDLE);

		// record all samples from the file
		press_button(BTN_START);
		check_state(o_state, S_RECD);
		repeat (3) @(posedge i_clk);
		for (int i = 0; i < num_samples; i++) begin
			send_sample(sample_t'(tests_mem[1 + i]));
		end
		// last write handshake is 4 clocks
		repeat (6) @(posedge i_clk);
		press_button(BTN_STOP);
		check_state(o_state, S_IDLE);
		check_addr(o_end_addr, addr_t'(num_samples), "end address");

		// playback scenarios, 3 words each
		for (int sc = 0; sc < NUM_SCEN; sc++) begin
			base      = 1 + num_samples + 3 * sc;
			fast_mode = tests_mem[base][0];
			spd       = int'(tests_mem[base + 1]);
			pause_at  = int'(tests_mem[base + 2]);
			build_expected(fast_mode, spd, num_samples);
			@(posedge i_clk);
			i_fast      <= fast_mode;
			i_speed     <= speed_t'(spd);
			i_play_mode <= 1'b1;
			press_button(BTN_START);
			check_state(o_state, S_PLAY);
			repeat (3) @(posedge i_clk);
			for (int k = 0; k < exp_idx.size(); k++) begin
				if (pause_at != 0 && k == pause_at) begin
					pause_window();
				end
				play_frame(exp_idx[k]);
			end
			wait_idle();
		end

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// run limit from sample and scenario counts
	initial begin
		#1;
		repeat (watchdog_cycles) @(posedge i_clk);
		$display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("errors: %0d", errors);
		$display("Test failed");
		$finish;
	end

endmodule

// File: testbench/audio_properties.sv
`timescale 1ns/1ps

module audio_properties import audio_pkg::*; (
	input logic        i_clk,
	input logic        i_rst_n,
	input logic        i_wr_req,
	input logic        i_wr_ack,
	input logic        i_rd_req,
	input logic        i_rd_ack,
	input logic        i_rec_en,
	input logic        i_play_en,
	input logic        i_dac_valid,
	input ctrl_state_t i_state
);

	// ack only answers a live request
	wr_ack_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_wr_ack) |-> i_wr_req)
		else $error("write ack rose without a write request");
	rd_ack_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_rd_ack) |-> i_rd_req)
		else $error("read ack rose without a read request");

	// req stays up until acknowledged
	wr_req_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_wr_req && !i_wr_ack) |=> i_wr_req)
		else $error("write request dropped before ack");
	rd_req_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_rd_req && !i_rd_ack) |=> i_rd_req)
		else $error("read request dropped before ack");

	// record and play are exclusive
	mode_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_rec_en && i_play_en))
		else $error("record and play enabled together");

	// dac output only while playing
	dac_in_play: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dac_valid |-> (i_state == S_PLAY))
		else $error("dac valid outside play state");

endmodule

bind audio_top audio_properties props_i (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_wr_req    (wr_req),
	.i_wr_ack    (wr_ack),
	.i_rd_req    (rd_req),
	.i_rd_ack    (rd_ack),
	.i_rec_en    (rec_en),
	.i_play_en   (play_en),
	.i_dac_valid (o_dac_valid),
	.i_state     (o_state)
);

// File: src/audio_top.sv
`timescale 1ns/1ps

module audio_top import audio_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_start,
	input  logic        i_pause,
	input  logic        i_stop,
	input  logic        i_play_mode,
	input  logic        i_fast,
	input  speed_t      i_speed,
	input  logic        i_bit_en,
	input  logic        i_adc_bit,
	input  logic        i_frame,
	output sample_t     o_dac_data,
	output logic        o_dac_valid,
	output addr_t       o_end_addr,
	output ctrl_state_t o_state
);

	// controller to datapath
	logic    rec_en;
	logic    play_en;
	logic    rec_restart;
	logic    play_restart;
	logic    play_done;
	addr_t   rec_addr;

	// recorder to store
	logic    wr_req;
	logic    wr_ack;
	addr_t   wr_addr;
	sample_t wr_data;

	// player to store
	logic    rd_req;
	logic    rd_ack;
	addr_t   rd_addr;
	sample_t rd_data;

	audio_ctrl ctrl_i (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_start        (i_start),
		.i_pause        (i_pause),
		.i_stop         (i_stop),
		.i_play_mode    (i_play_mode),
		.i_play_done    (play_done),
		.i_rec_addr     (rec_addr),
		.o_rec_en       (rec_en),
		.o_play_en      (play_en),
		.o_rec_restart  (rec_restart),
		.o_play_restart (play_restart),
		.o_end_addr     (o_end_addr),
		.o_state        (o_state)
	);

	// producer side
	audio_recorder recorder_i (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_en       (rec_en),
		.i_restart  (rec_restart),
		.i_bit_en   (i_bit_en),
		.i_adc_bit  (i_adc_bit),
		.i_wr_ack   (wr_ack),
		.o_wr_req   (wr_req),
		.o_wr_addr  (wr_addr),
		.o_wr_data  (wr_data),
		.o_rec_addr (rec_addr)
	);

	sample_store store_i (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_req  (wr_req),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_rd_req  (rd_req),
		.i_rd_addr (rd_addr),
		.o_wr_ack  (wr_ack),
		.o_rd_ack  (rd_ack),
		.o_rd_data (rd_data)
	);

	// consumer side, stops at the latched end address
	audio_player player_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_en        (play_en),
		.i_restart   (play_restart),
		.i_frame     (i_frame),
		.i_fast      (i_fast),
		.i_speed     (i_speed),
		.i_end_addr  (o_end_addr),
		.i_rd_ack    (rd_ack),
		.i_rd_data   (rd_data),
		.o_rd_req    (rd_req),
		.o_rd_addr   (rd_addr),
		.o_dac_data  (o_dac_data),
		.o_dac_valid (o_dac_valid),
		.o_play_done (play_done)
	);

endmodule

// File: src/audio_ctrl.sv
`timescale 1ns/1ps

module audio_ctrl import audio_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_start,
	input  logic        i_pause,
	input  logic        i_stop,
	input  logic        i_play_mode,
	input  logic        i_play_done,
	input  addr_t       i_rec_addr,
	output logic        o_rec_en,
	output logic        o_play_en,
	output logic        o_rec_restart,
	output logic        o_play_restart,
	output addr_t       o_end_addr,
	output ctrl_state_t o_state
);

	ctrl_state_t state_r, state_w;
	addr_t       end_addr_r, end_addr_w;
	logic        rec_restart_r, rec_restart_w;
	logic        play_restart_r, play_restart_w;

	always_comb begin
		state_w        = state_r;
		end_addr_w     = end_addr_r;
		rec_restart_w  = 1'b0;
		play_restart_w = 1'b0;
		case (state_r)
			S_IDLE: begin
				if (i_start) begin
					if (!i_play_mode) begin
						state_w       = S_RECD;
						rec_restart_w = 1'b1;
					end else if (end_addr_r != '0) begin
						// nothing recorded yet, play stays blocked
						state_w        = S_PLAY;
						play_restart_w = 1'b1;
					end
				end
			end
			S_RECD, S_RECD_PAUSE: begin
				// pause before stop, start only resumes from pause
				if (i_pause && state_r == S_RECD) begin
					state_w = S_RECD_PAUSE;
				end else if (i_start && state_r == S_RECD_PAUSE) begin
					state_w = S_RECD;
				end else if (i_stop) begin
					// leaving record, keep sample count as play limit
					state_w    = S_IDLE;
					end_addr_w = i_rec_addr;
				end
			end
			S_PLAY: begin
				if (i_pause) begin
					state_w = S_PLAY_PAUSE;
				end else if (i_stop || i_play_done) begin
					state_w = S_IDLE;
				end
			end
			S_PLAY_PAUSE: begin
				if (i_start) begin
					state_w = S_PLAY;
				end else if (i_stop) begin
					state_w = S_IDLE;
				end
			end
			default: begin
				state_w = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r        <= S_IDLE;
			end_addr_r     <= '0;
			rec_restart_r  <= 1'b0;
			play_restart_r <= 1'b0;
		end else begin
			state_r        <= state_w;
			end_addr_r     <= end_addr_w;
			rec_restart_r  <= rec_restart_w;
			play_restart_r <= play_restart_w;
		end
	end

	// enables follow state, restarts line up with first active clock
	assign o_rec_en       = (state_r == S_RECD);
	assign o_play_en      = (state_r == S_PLAY);
	assign o_rec_restart  = rec_restart_r;
	assign o_play_restart = play_restart_r;
	assign o_end_addr     = end_addr_r;
	assign o_state        = state_r;

endmodule

// File: src/audio_player.sv
`timescale 1ns/1ps

module audio_player import audio_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_en,
	input  logic    i_restart,
	input  logic    i_frame,
	input  logic    i_fast,
	input  speed_t  i_speed,
	input  addr_t   i_end_addr,
	input  logic    i_rd_ack,
	input  sample_t i_rd_data,
	output logic    o_rd_req,
	output addr_t   o_rd_addr,
	output sample_t o_dac_data,
	output logic    o_dac_valid,
	output logic    o_play_done
);

	logic            rd_req_r;
	addr_t           addr_r;
	speed_t          frame_cnt_r;
	sample_t         dac_hold_r;
	logic            play_done_r;

	logic            fetch_open;
	logic            fetch_back;
	logic            present;
	logic            at_end;
	logic [ADDR_W:0] step;
	logic [ADDR_W:0] next_addr;
	speed_t          frame_cnt_nxt;

	// busy from req up until ack back down
	assign fetch_open = rd_req_r || i_rd_ack;
	// first clock of ack
	assign fetch_back = rd_req_r && i_rd_ack;
	// sample returned during pause is dropped, same address refetched on resume
	assign present    = fetch_back && i_en;

	// address step for the frame just presented
	always_comb begin
		frame_cnt_nxt = '0;
		if (i_fast) begin
			// skip speed samples
			step = {1'b0, ADDR_W'(i_speed)} + 1'b1;
		end else if (frame_cnt_r >= i_speed) begin
			// slow, held speed+1 frames, now move on
			step = 1;
		end else begin
			step          = '0;
			frame_cnt_nxt = frame_cnt_r + 1'b1;
		end
	end

	// one extra bit so a large step past the top is still seen as the end
	assign next_addr = {1'b0, addr_r} + step;
	assign at_end    = next_addr >= {1'b0, i_end_addr};

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rd_req_r    <= 1'b0;
			addr_r      <= '0;
			frame_cnt_r <= '0;
			play_done_r <= 1'b0;
		end else begin
			play_done_r <= present && at_end;
			if (i_restart) begin
				addr_r      <= '0;
				frame_cnt_r <= '0;
			end else if (present) begin
				addr_r      <= next_addr[ADDR_W-1:0];
				frame_cnt_r <= frame_cnt_nxt;
			end
			// a frame during an open fetch is lost
			if (fetch_back) begin
				rd_req_r <= 1'b0;
			end else if (i_frame && i_en && !fetch_open) begin
				rd_req_r <= 1'b1;
			end
		end
	end

	// dac word kept between frames
	always_ff @(posedge i_clk) begin
		if (present) begin
			dac_hold_r <= i_rd_data;
		end
	end

	assign o_rd_req    = rd_req_r;
	assign o_rd_addr   = addr_r;
	assign o_dac_valid = present;
	assign o_dac_data  = present ? i_rd_data : dac_hold_r;
	assign o_play_done = play_done_r;

endmodule

// File: src/sample_store.sv
`timescale 1ns/1ps

module sample_store import audio_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_wr_req,
	input  addr_t   i_wr_addr,
	input  sample_t i_wr_data,
	input  logic    i_rd_req,
	input  addr_t   i_rd_addr,
	output logic    o_wr_ack,
	output logic    o_rd_ack,
	output sample_t o_rd_data
);

	localparam int DEPTH = 2 ** ADDR_W;

	// single port array, one access per clock
	sample_t mem [DEPTH];
	sample_t rd_data_r;

	logic    wr_ack_r;
	logic    rd_ack_r;
	logic    wr_sel;
	logic    rd_sel;

	// new request = req high while own ack still low
	assign wr_sel = i_wr_req && !wr_ack_r;
	// write wins a same-cycle collision, read waits a clock
	assign rd_sel = i_rd_req && !rd_ack_r && !wr_sel;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ack_r <= 1'b0;
			rd_ack_r <= 1'b0;
		end else begin
			// ack goes up one clock after req, down one clock after req drops
			if (wr_sel) begin
				wr_ack_r <= 1'b1;
			end else if (!i_wr_req) begin
				wr_ack_r <= 1'b0;
			end
			if (rd_sel) begin
				rd_ack_r <= 1'b1;
			end else if (!i_rd_req) begin
				rd_ack_r <= 1'b0;
			end
		end
	end

	// array access
	always_ff @(posedge i_clk) begin
		if (wr_sel) begin
			mem[i_wr_addr] <= i_wr_data;
		end else if (rd_sel) begin
			// held until the next read, so valid for the whole ack phase
			rd_data_r <= mem[i_rd_addr];
		end
	end

	assign o_wr_ack  = wr_ack_r;
	assign o_rd_ack  = rd_ack_r;
	assign o_rd_data = rd_data_r;

endmodule

// File: src/audio_recorder.sv
`timescale 1ns/1ps

module audio_recorder import audio_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_en,
	input  logic    i_restart,
	input  logic    i_bit_en,
	input  logic    i_adc_bit,
	input  logic    i_wr_ack,
	output logic    o_wr_req,
	output addr_t   o_wr_addr,
	output sample_t o_wr_data,
	output addr_t   o_rec_addr
);

	// deserializer
	sample_t  shift_r;
	bit_cnt_t bit_cnt_r;
	// write side of the store handshake
	logic     wr_req_r;
	sample_t  wr_data_r;
	addr_t    addr_r;

	logic     bit_take;
	logic     sample_done;
	logic     wr_open;
	logic     store_full;
	sample_t  shift_nxt;

	// bits only count while recording, so pause holds the position
	assign bit_take    = i_en && i_bit_en;
	// msb arrives first
	assign shift_nxt   = {shift_r[SAMPLE_W-2:0], i_adc_bit};
	assign sample_done = bit_take && (bit_cnt_r == bit_cnt_t'(SAMPLE_W - 1));
	// write still in progress until ack has fallen
	assign wr_open     = wr_req_r || i_wr_ack;
	// last address reached, no more writes
	assign store_full  = (addr_r == '1);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bit_cnt_r <= '0;
		end else if (i_restart) begin
			// a partial sample left over from a stop is thrown away here
			bit_cnt_r <= '0;
		end else if (bit_take) begin
			bit_cnt_r <= sample_done ? '0 : bit_cnt_r + 1'b1;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_req_r <= 1'b0;
			addr_r   <= '0;
		end else if (i_restart) begin
			wr_req_r <= 1'b0;
			addr_r   <= '0;
		end else if (wr_req_r) begin
			// ack seen, release req and count the sample
			if (i_wr_ack) begin
				wr_req_r <= 1'b0;
				addr_r   <= addr_r + 1'b1;
			end
		end else if (sample_done && !i_wr_ack && !store_full) begin
			wr_req_r <= 1'b1;
		end
	end

	// payload, held stable for the whole handshake
	always_ff @(posedge i_clk) begin
		if (bit_take) begin
			shift_r <= shift_nxt;
		end
		if (sample_done && !wr_open) begin
			wr_data_r <= shift_nxt;
		end
	end

	assign o_wr_req   = wr_req_r;
	assign o_wr_addr  = addr_r;
	assign o_wr_data  = wr_data_r;
	assign o_rec_addr = addr_r;

endmodule

// File: src/audio_pkg.sv
package audio_pkg;

	// sample and memory geometry
	localparam int SAMPLE_W = 16;
	localparam int ADDR_W   = 10;
	localparam int SPEED_W  = 4;

	// one audio word as seen by ADC and DAC
	typedef logic [SAMPLE_W-1:0] sample_t;
	// store address, also used as a sample count
	typedef logic [ADDR_W-1:0] addr_t;
	// playback speed switch value
	typedef logic [SPEED_W-1:0] speed_t;
	// bit position inside a sample while shifting in
	typedef logic [$clog2(SAMPLE_W)-1:0] bit_cnt_t;

	// record / play mode machine
	typedef enum logic [2:0] {
		S_IDLE,
		S_RECD,
		S_RECD_PAUSE,
		S_PLAY,
		S_PLAY_PAUSE
	} ctrl_state_t;

endpackage
